/* src/step_pkg.sv */
/* Convolution mode and lane delay rule for the step buffer.
   The RTL sizes its delay lines from lane_delay and the testbench predicts timing with it */
package step_pkg;

    // Default number of lanes in a beat
    parameter int STEPS = 4;

    // Default accumulator latency, has to be 3 or more
    parameter int ACC_LATENCY = 4;

    // 1x1 keeps the lanes aligned, nxm skews them in steps
    typedef enum logic {
        MODE_1X1 = 1'b0,
        MODE_NXM = 1'b1
    } conv_mode_t;

    // Cycles that lane i spends inside the step buffer
    // In nxm mode each lane trails the previous one by acc_latency-2 cycles so that the
    // accumulator cascade takes the partial sum from lane i-1 right behind lane i's last
    // product. The extra one keeps lane 0 at a single stage like the 1x1 path
    function automatic int lane_delay(
        input int         lane,
        input int         acc_latency,
        input conv_mode_t mode
    );
        int delay;
        if (mode == MODE_1X1) begin
            delay = 1;  // Every lane moves together
        end else begin
            delay = lane * (acc_latency - 2) + 1;
        end
        return delay;
    endfunction

endpackage

/* src/stream_pkg.sv */
/* Stream word types carried through every lane of the step buffer.
   Import where a module moves lane beats or whole input beats */
package stream_pkg;

    // The lane count comes from the step description
    import step_pkg::*;

    // Default data word width, the top level passes its own copy down
    parameter int WORD_WIDTH = 8;

    // Width of the user sideband riding with each word
    parameter int USER_WIDTH = 4;

    // One lane of one beat
    // Data sits in the upper bits so a lane can be split as {data, last, user}
    typedef struct packed {
        logic [WORD_WIDTH-1:0] data;  // Payload word for this lane
        logic                  last;  // End of packet marker
        logic [USER_WIDTH-1:0] user;  // Sideband bits that stay with the word
    } lane_beat_t;

    // A full beat with one word per lane
    // The same layout serves the input side and the skewed output side
    typedef lane_beat_t [STEPS-1:0] beat_vec_t;

endpackage

/* src/beat_fanout.sv */
/* Input stage of the step buffer slice. Accepts beats on a valid/ready handshake,
   latches the mode and holds back mode changes until no beat is in flight */
`timescale 1ns/1ps

module beat_fanout
    import step_pkg::*;
    import stream_pkg::*;
(
    input  logic       aclk,
    input  logic       reset,
    input  logic       en,
    input  logic       in_valid,
    output logic       in_ready,
    input  beat_vec_t  in_beat,
    input  conv_mode_t in_mode,
    input  logic       drain_pulse,
    output logic       fan_valid,
    output beat_vec_t  fan_beat,
    output conv_mode_t fan_mode
);

    // Worst case occupancy is the deepest nxm lane plus the fanout and output registers
    localparam int MAX_IN_FLIGHT = lane_delay(STEPS - 1, ACC_LATENCY, MODE_NXM) + 2;
    localparam int CNT_WIDTH     = $clog2(MAX_IN_FLIGHT + 1);

    logic                 started;      // Low for the first cycle out of reset
    conv_mode_t           mode_q;       // Mode that the beats in flight were accepted under
    logic [CNT_WIDTH-1:0] in_flight;    // Beats accepted but not yet drained from the last lane
    logic                 mode_pending; // A beat is offered with a different mode
    logic                 accept;

    // A new mode only counts once a beat actually carries it
    assign mode_pending = in_valid && (in_mode != mode_q);

    // Mode changes wait for an empty pipeline while a matching mode lets ready follow en
    assign in_ready = started && en && !mode_pending;
    assign accept   = in_valid && in_ready;
    assign fan_mode = mode_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // Drain pulses only come with out_ready high, so en is high whenever one lands
    always_ff @(posedge aclk) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + CNT_WIDTH'(accept) - CNT_WIDTH'(drain_pulse);
        end
    end

    // The lane delays switch here, and only when every lane is empty
    always_ff @(posedge aclk) begin
        if (reset) begin
            mode_q <= MODE_1X1;
        end else if (en && mode_pending && (in_flight == '0)) begin
            mode_q <= in_mode;  // The offered beat is taken on a later cycle
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            fan_valid <= 1'b0;
        end else if (en) begin
            fan_valid <= accept;
        end
    end

    // The beat payload moves with the stall enable like every other stage
    always_ff @(posedge aclk) begin
        if (en) begin
            fan_beat <= in_beat;
        end
    end

endmodule

/* src/n_delay_stream.sv */
/* Delay line for one lane with N enabled stages and a one stage short path.
   Instantiated once per lane by the step buffer */
`timescale 1ns/1ps

module n_delay_stream
    import stream_pkg::*;
#(
    parameter int N          = 1,
    parameter int WORD_WIDTH = stream_pkg::WORD_WIDTH
)(
    input  logic       aclk,
    input  logic       reset,
    input  logic       en,
    input  logic       short_path,
    input  logic       valid_in,
    input  lane_beat_t beat_in,
    output logic       valid_out,
    output lane_beat_t beat_out
);

    // Width of the last and user bits below the data word
    localparam int SIDE_WIDTH = $bits(lane_beat_t) - WORD_WIDTH;

    logic [N-1:0]          valid_q;
    logic [WORD_WIDTH-1:0] data_q [N];
    logic [SIDE_WIDTH-1:0] side_q [N];

    if (N < 1) begin : g_depth_check
        $error("n_delay_stream needs at least one stage");
    end

    // Valid bits stop past stage 0 on the short path
    // so a later switch to the long path finds no stale copies in the deep stages
    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (en) begin
            valid_q[0] <= valid_in;
            for (int k = 1; k < N; k++) begin
                valid_q[k] <= valid_q[k-1] && !short_path;
            end
        end
    end

    // Word and sideband shift together through the stages
    always_ff @(posedge aclk) begin
        if (en) begin
            {data_q[0], side_q[0]} <= beat_in;
            for (int k = 1; k < N; k++) begin
                data_q[k] <= data_q[k-1];
                side_q[k] <= side_q[k-1];
            end
        end
    end

    // Short path taps the first stage for a single cycle of delay
    assign valid_out = short_path ? valid_q[0] : valid_q[N-1];
    assign beat_out  = short_path ? lane_beat_t'({data_q[0], side_q[0]})
                                  : lane_beat_t'({data_q[N-1], side_q[N-1]});

endmodule

/* src/step_buffer.sv */
/* Step buffer that skews the lanes of each beat for the accumulator cascade.
   Lane i sees lane_delay(i) cycles, all of them one cycle in 1x1 mode */
`timescale 1ns/1ps

module step_buffer
    import step_pkg::*;
    import stream_pkg::*;
#(
    parameter int STEPS       = step_pkg::STEPS,
    parameter int ACC_LATENCY = step_pkg::ACC_LATENCY,
    parameter int WORD_WIDTH  = stream_pkg::WORD_WIDTH
)(
    input  logic             aclk,
    input  logic             reset,
    input  logic             en,
    input  logic             fan_valid,
    input  beat_vec_t        fan_beat,
    input  conv_mode_t       fan_mode,
    output logic [STEPS-1:0] lane_valid,
    output beat_vec_t        lane_beat
);

    logic       short_path;          // Shared by every lane
    logic       valid_w [STEPS];     // Per lane outputs before packing
    lane_beat_t beat_w  [STEPS];

    // With a latency below 3 the step would be zero or negative
    if (ACC_LATENCY < 3) begin : g_latency_check
        $error("step_buffer needs ACC_LATENCY of 3 or more");
    end

    assign short_path = (fan_mode == MODE_1X1);

    // Each lane is built for its nxm depth and cut short in 1x1 mode
    for (genvar i = 0; i < STEPS; i++) begin : g_lane
        localparam int DEPTH = lane_delay(i, ACC_LATENCY, MODE_NXM);

        n_delay_stream #(
            .N          (DEPTH),
            .WORD_WIDTH (WORD_WIDTH)
        ) delay_i (
            .aclk       (aclk),
            .reset      (reset),
            .en         (en),
            .short_path (short_path),
            .valid_in   (fan_valid),    // All lanes of a beat enter together
            .beat_in    (fan_beat[i]),
            .valid_out  (valid_w[i]),
            .beat_out   (beat_w[i])
        );
    end

    always_comb begin
        for (int i = 0; i < STEPS; i++) begin
            lane_valid[i] = valid_w[i];
            lane_beat[i]  = beat_w[i];
        end
    end

endmodule

/* src/skew_collector.sv */
/* Output stage for the skewed lanes. Registers each lane, raises the shared
   stall enable and reports when a beat of the last lane leaves */
`timescale 1ns/1ps

module skew_collector
    import stream_pkg::*;
#(
    parameter int STEPS      = step_pkg::STEPS,
    parameter int WORD_WIDTH = stream_pkg::WORD_WIDTH
)(
    input  logic             aclk,
    input  logic             reset,
    input  logic [STEPS-1:0] lane_valid,
    input  beat_vec_t        lane_beat,
    input  logic             out_ready,
    output logic [STEPS-1:0] out_valid,
    output beat_vec_t        out_beat,
    output logic             en,
    output logic             drain_pulse
);

    // The beat layout is fixed by the package, the parameters have to agree with it
    if ($bits(beat_vec_t) != STEPS * (WORD_WIDTH + USER_WIDTH + 1)) begin : g_width_check
        $error("skew_collector parameters do not match beat_vec_t");
    end

    logic any_valid;  // Some lane holds a word waiting to go out

    assign any_valid = |out_valid;

    // One ready covers the whole vector
    // A held word with no ready freezes every stage back to the input
    assign en = out_ready || !any_valid;

    // The last lane is always the deepest one
    // so its beat leaving means that the whole beat has left
    assign drain_pulse = out_valid[STEPS-1] && out_ready;

    // Lanes flagged valid transfer on this edge when ready is high
    // and get replaced by whatever the buffer offers next
    always_ff @(posedge aclk) begin
        if (reset) begin
            out_valid <= '0;
        end else if (en) begin
            out_valid <= lane_valid;
        end
    end

    // Output registers also break the fanout from the buffer to the consumers
    always_ff @(posedge aclk) begin
        if (en) begin
            out_beat <= lane_beat;  // Words for empty lanes are don't care
        end
    end

endmodule

/* src/conv_step_top.sv */
/* Top level of the step buffer slice: fanout, skewing lanes and output collector.
   Drive beats on the in_ side and take each lane from the out_ side */
`timescale 1ns/1ps

module conv_step_top
    import step_pkg::*;
    import stream_pkg::*;
#(
    parameter int STEPS       = step_pkg::STEPS,
    parameter int ACC_LATENCY = step_pkg::ACC_LATENCY,
    parameter int WORD_WIDTH  = stream_pkg::WORD_WIDTH
)(
    input  logic             aclk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  beat_vec_t        in_beat,
    input  conv_mode_t       in_mode,
    output logic [STEPS-1:0] out_valid,
    output beat_vec_t        out_beat,
    input  logic             out_ready
);

    // The in-flight counter in the fanout is sized from the package latency
    if (ACC_LATENCY > step_pkg::ACC_LATENCY) begin : g_latency_check
        $error("ACC_LATENCY above the package value overflows the in-flight count");
    end

    logic             en;          // Pipeline wide clock enable
    logic             fan_valid;
    beat_vec_t        fan_beat;
    conv_mode_t       fan_mode;
    logic [STEPS-1:0] lane_valid;
    beat_vec_t        lane_beat;
    logic             drain_pulse; // Last lane handed a beat to the consumer

    beat_fanout fanout_i (
        .aclk        (aclk),
        .reset       (reset),
        .en          (en),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_beat     (in_beat),
        .in_mode     (in_mode),
        .drain_pulse (drain_pulse),
        .fan_valid   (fan_valid),
        .fan_beat    (fan_beat),
        .fan_mode    (fan_mode)
    );

    step_buffer #(
        .STEPS       (STEPS),
        .ACC_LATENCY (ACC_LATENCY),
        .WORD_WIDTH  (WORD_WIDTH)
    ) buffer_i (
        .aclk        (aclk),
        .reset       (reset),
        .en          (en),
        .fan_valid   (fan_valid),
        .fan_beat    (fan_beat),
        .fan_mode    (fan_mode),
        .lane_valid  (lane_valid),
        .lane_beat   (lane_beat)
    );

    skew_collector #(
        .STEPS       (STEPS),
        .WORD_WIDTH  (WORD_WIDTH)
    ) collector_i (
        .aclk        (aclk),
        .reset       (reset),
        .lane_valid  (lane_valid),
        .lane_beat   (lane_beat),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .en          (en),
        .drain_pulse (drain_pulse)
    );

endmodule

/* test/step_sva.sv */
/* Output stage protocol checks on the stall enable, the drain pulse and reset.
   Bound into skew_collector from the testbench */
`timescale 1ns/1ps

module step_sva #(
    parameter int STEPS = 4
)(
    input logic             aclk,
    input logic             reset,
    input logic             out_ready,
    input logic [STEPS-1:0] out_valid,
    input logic             en,
    input logic             drain_pulse
);

    int fail_count = 0;  // Assertion failures seen so far

    // The pipeline freezes exactly when a held word meets a low ready
    stall_rule: assert property (@(posedge aclk) disable iff (reset)
        !en == (!out_ready && (|out_valid)))
    else begin
        $error("en disagrees with out_ready and out_valid");
        fail_count++;
    end

    // A drain is the last lane handing its word to the consumer
    drain_rule: assert property (@(posedge aclk) disable iff (reset)
        drain_pulse |-> (out_valid[STEPS-1] && out_ready))
    else begin
        $error("drain_pulse without a transfer on the last lane");
        fail_count++;
    end

    clear_rule: assert property (@(posedge aclk) reset |=> (out_valid == '0))
    else begin
        $error("out_valid not clear on the cycle after reset");
        fail_count++;
    end

endmodule

/* test/tb_conv_step.sv */
/* Directed testbench for the step buffer slice. Sends beats in both modes and
   checks every lane against the lane delay rule of the slice */
`timescale 1ns/1ps

module tb_conv_step
    import step_pkg::*;
    import stream_pkg::*;
();

    localparam int LAT     = 4;    // Accumulator latency of the DUT
    localparam int TIMEOUT = 200;  // Cycles that any single wait may take

    logic             aclk = 1'b0;
    logic             reset;
    logic             in_valid;
    logic             in_ready;
    beat_vec_t        in_beat;
    conv_mode_t       in_mode;
    logic [STEPS-1:0] out_valid;
    beat_vec_t        out_beat;
    logic             out_ready;

    lane_beat_t exp_beat [STEPS][$];  // Beats that each lane still owes in order of arrival
    int         exp_edge [STEPS][$];  // Edge on which each owed beat should be taken
    conv_mode_t last_mode = MODE_1X1;
    string      test_name = "none";
    logic       check_timing = 1'b0;  // Only meaningful with out_ready held high
    logic       rand_ready = 1'b0;
    int         seed = 32'hd06963c4;
    int         rnd;
    int         cycle = 0;
    int         errors = 0;
    int         checks = 0;

    always #50 aclk = ~aclk;

    conv_step_top #(.STEPS(STEPS), .ACC_LATENCY(LAT), .WORD_WIDTH(WORD_WIDTH)) dut_i (.*);

    bind skew_collector step_sva #(.STEPS(STEPS)) sva_i (.*);

    task automatic check_beat(input string name, input lane_beat_t exp, input lane_beat_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected data/last/user %h/%b/%h, got %h/%b/%h", name,
                     exp.data, exp.last, exp.user, act.data, act.last, act.user);
        end
    endtask

    task automatic check_valid(input string name, input logic [STEPS-1:0] exp,
                               input logic [STEPS-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected out_valid %b, got %b", name, exp, act);
        end
    endtask

    task automatic check_cycle(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("[FAIL] %s: expected transfer on edge %0d, got edge %0d", name, exp, act);
        end
    endtask

    // Expected cycles that one lane spends in the step buffer in the given mode
    function automatic int expected_delay(input int lane, input conv_mode_t m);
        if (m == MODE_NXM) begin
            return lane * (LAT - 2) + 1;  // Each lane trails the one before by LAT-2 cycles
        end
        return 1;  // In 1x1 mode every lane takes a single stage
    endfunction

    // Each lane gets its own word and every fourth beat closes a packet
    function automatic beat_vec_t make_beat(input int n);
        beat_vec_t b;
        for (int i = 0; i < STEPS; i++) begin
            b[i].data = WORD_WIDTH'(n * 7 + i * 61 + 3);
            b[i].last = (n % 4) == 3;
            b[i].user = USER_WIDTH'(n + i);
        end
        return b;
    endfunction

    function automatic int pending();
        int total;
        total = 0;
        for (int i = 0; i < STEPS; i++) begin
            total += exp_beat[i].size();
        end
        return total;
    endfunction

    // Scoreboard update with the values that the DUT sampled on this edge
    task automatic watch_lanes();
        int due;
        if (in_valid && in_ready) begin
            if (in_mode != last_mode && exp_beat[STEPS-1].size() != 0) begin
                errors++;  // Delays would change under live data
                $display("%s: beat with a new mode taken while the last lane held data",
                         test_name);
            end
            last_mode = in_mode;
            for (int i = 0; i < STEPS; i++) begin
                exp_beat[i].push_back(in_beat[i]);
                // The lane stages follow this edge and the collector adds one edge before the take
                exp_edge[i].push_back(cycle + expected_delay(i, in_mode) + 2);
            end
        end
        for (int i = 0; i < STEPS; i++) begin
            if (out_valid[i] && out_ready) begin
                if (exp_beat[i].size() == 0) begin
                    errors++;
                    $display("%s: lane %0d delivered a beat that was never sent", test_name, i);
                end else begin
                    due = exp_edge[i].pop_front();
                    check_beat(test_name, exp_beat[i].pop_front(), out_beat[i]);
                    if (check_timing) begin
                        check_cycle(test_name, due, cycle);
                    end
                end
            end
        end
    endtask

    // One clock edge with the scoreboard and the ready pattern kept in step
    task automatic tick();
        @(posedge aclk);
        cycle++;
        if (!reset) begin
            watch_lanes();
        end
        if (rand_ready) begin
            rnd = $random(seed);
            out_ready <= rnd[0];
        end
    endtask

    task automatic send_beat(input beat_vec_t b, input conv_mode_t m);
        int waited;
        in_valid <= 1'b1;
        in_beat  <= b;
        in_mode  <= m;
        waited = 0;
        tick();
        while (!in_ready && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (!in_ready) begin
            errors++;
            $display("%s: beat not accepted within %0d cycles", test_name, TIMEOUT);
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!in_ready && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (!in_ready) begin
            errors++;
            $display("%s: in_ready did not rise within %0d cycles", test_name, TIMEOUT);
        end
    endtask

    task automatic wait_drain();
        int waited;
        in_valid <= 1'b0;
        waited = 0;
        while (pending() != 0 && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (pending() != 0) begin
            errors++;
            $display("%s: %0d lane beats never came out", test_name, pending());
        end
    endtask

    task automatic after_reset();
        test_name = "reset";
        tick();
        check_valid(test_name, '0, out_valid);
        wait_ready();
    endtask

    task automatic aligned_1x1();
        test_name = "aligned_1x1";
        check_timing = 1'b1;
        for (int n = 0; n < 6; n++) begin
            send_beat(make_beat(n), MODE_1X1);
        end
        wait_drain();
    endtask

    // Switch requested with 1x1 beats still in the lanes
    task automatic mode_switch();
        test_name = "mode_change";
        check_timing = 1'b1;
        for (int n = 8; n < 12; n++) begin
            send_beat(make_beat(n), MODE_1X1);
        end
        send_beat(make_beat(12), MODE_NXM);
        check_valid(test_name, '0, out_valid);  // Every lane empty when it is taken
        for (int n = 13; n < 16; n++) begin
            send_beat(make_beat(n), MODE_NXM);
        end
        wait_drain();
    endtask

    task automatic stepped_nxm();
        test_name = "stepped_nxm";
        check_timing = 1'b1;
        for (int n = 16; n < 22; n++) begin
            send_beat(make_beat(n), MODE_NXM);
        end
        wait_drain();
    endtask

    task automatic back_pressure(input conv_mode_t m, input string name);
        test_name = name;
        check_timing = 1'b0;
        rand_ready = 1'b1;
        for (int n = 32; n < 48; n++) begin
            send_beat(make_beat(n), m);
        end
        wait_drain();
        rand_ready = 1'b0;
        out_ready <= 1'b1;
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_beat = '0;
        in_mode = MODE_1X1;
        out_ready = 1'b1;
        repeat (8) tick();
        reset <= 1'b0;
        after_reset();
        aligned_1x1();
        mode_switch();
        stepped_nxm();
        back_pressure(MODE_NXM, "back_pressure_nxm");
        back_pressure(MODE_1X1, "back_pressure_1x1");
        errors += dut_i.collector_i.sva_i.fail_count;
        $display("Run complete with %0d checks and %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
src/step_pkg.sv
src/stream_pkg.sv
src/beat_fanout.sv
src/n_delay_stream.sv
src/step_buffer.sv
src/skew_collector.sv
src/conv_step_top.sv
test/step_sva.sv
test/tb_conv_step.sv

/* Makefile */
# Verilator build and run of the step buffer testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_conv_step -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
